//--- verilog.f
+incdir+.
salamander_pkg.sv
rom_download_router.sv
sdram_prog_writer.sv
bram_prog_writer.sv
control_panel.sv
salamander_loader_top.sv
tb_salamander_loader.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_salamander_loader
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST)) salamander_consts.svh

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_salamander_loader.sv
`timescale 1ns/1ps
`include "salamander_consts.svh"

module tb_salamander_loader;

import salamander_pkg::*;

logic         emu_mclk;
logic         emu_initrst;
ioctl_index_t ioctl_index;
ioctl_addr_t  ioctl_addr;
byte_t        ioctl_data;
logic         ioctl_wr;
joystick_t    joystick0;
joystick_t    joystick1;
logic         prog_sdram_ack;

wire          ioctl_wait;
wire          prog_sdram_en;
wire          prog_sdram_wr;
sdram_addr_t  prog_sdram_addr;
sdram_word_t  prog_sdram_din;
byte_mask_t   prog_sdram_mask;
sdram_bank_t  prog_sdram_ba;
wire          prog_bram_en;
wire          prog_bram_wr;
bram_addr_t   prog_bram_addr;
byte_t        prog_bram_din;
wire          prog_bram_sndrom_cs;
wire          prog_bram_vlmrom_cs;
byte_t        dipsw1;
byte_t        dipsw2;
byte_t        in0;
byte_t        in1;
byte_t        in2;
wire          rom_download_done;

logic         done_model;     // expected state of the done flag
dipsw3_t      dip3_model;     // last dip bank 3 written
logic [31:0]  lfsr;
int           errors;
int           sva_errors;
int           checks;
int           test_base;
logic         sdram_stb_exp;
logic         bram_stb_exp;

salamander_loader_top DUT (
    .i_EMU_MCLK             (emu_mclk           ),
    .i_EMU_INITRST          (emu_initrst        ),
    .i_ioctl_index          (ioctl_index        ),
    .i_ioctl_addr           (ioctl_addr         ),
    .i_ioctl_data           (ioctl_data         ),
    .i_ioctl_wr             (ioctl_wr           ),
    .o_ioctl_wait           (ioctl_wait         ),
    .i_joystick0            (joystick0          ),
    .i_joystick1            (joystick1          ),
    .i_prog_sdram_ack       (prog_sdram_ack     ),
    .o_prog_sdram_en        (prog_sdram_en      ),
    .o_prog_sdram_wr        (prog_sdram_wr      ),
    .o_prog_sdram_addr      (prog_sdram_addr    ),
    .o_prog_sdram_din       (prog_sdram_din     ),
    .o_prog_sdram_mask      (prog_sdram_mask    ),
    .o_prog_sdram_ba        (prog_sdram_ba      ),
    .o_prog_bram_en         (prog_bram_en       ),
    .o_prog_bram_wr         (prog_bram_wr       ),
    .o_prog_bram_addr       (prog_bram_addr     ),
    .o_prog_bram_din        (prog_bram_din      ),
    .o_prog_bram_sndrom_cs  (prog_bram_sndrom_cs),
    .o_prog_bram_vlmrom_cs  (prog_bram_vlmrom_cs),
    .o_dipsw1               (dipsw1             ),
    .o_dipsw2               (dipsw2             ),
    .o_in0                  (in0                ),
    .o_in1                  (in1                ),
    .o_in2                  (in2                ),
    .o_rom_download_done    (rom_download_done  )
);

initial begin
    emu_mclk = 1'b0;
    forever #50 emu_mclk = ~emu_mclk;   // 100 ns period
end

////////////////////////////////////////////////////////////
// protocol checks
////////////////////////////////////////////////////////////

// strobes as the host stream should produce them
assign sdram_stb_exp = ioctl_wr && (ioctl_index == `IOCTL_INDEX_ROM)
                       && !ioctl_addr[`BRAM_REGION_BIT] && !done_model;
assign bram_stb_exp  = ioctl_wr && (ioctl_index == `IOCTL_INDEX_ROM)
                       && ioctl_addr[`BRAM_REGION_BIT] && !done_model;

a_bram_pulse: assert property (@(posedge emu_mclk) disable iff (emu_initrst)
    bram_stb_exp |=> prog_bram_wr)
    else begin
        $display("ERROR t=%0t: block RAM write missing after a strobe", $time);
        sva_errors++;
    end

a_bram_quiet: assert property (@(posedge emu_mclk) disable iff (emu_initrst)
    !bram_stb_exp |=> !prog_bram_wr)
    else begin
        $display("ERROR t=%0t: block RAM write without a strobe", $time);
        sva_errors++;
    end

a_sdram_start: assert property (@(posedge emu_mclk) disable iff (emu_initrst)
    sdram_stb_exp && !prog_sdram_wr |=> prog_sdram_wr)
    else begin
        $display("ERROR t=%0t: SDRAM write did not start on an idle strobe", $time);
        sva_errors++;
    end

a_busy_hold: assert property (@(posedge emu_mclk) disable iff (emu_initrst)
    prog_sdram_wr && !prog_sdram_ack |=> prog_sdram_wr)
    else begin
        $display("ERROR t=%0t: SDRAM busy dropped without an ack", $time);
        sva_errors++;
    end

a_busy_release: assert property (@(posedge emu_mclk) disable iff (emu_initrst)
    prog_sdram_wr && prog_sdram_ack |=> !prog_sdram_wr)
    else begin
        $display("ERROR t=%0t: SDRAM busy stayed high after the ack", $time);
        sva_errors++;
    end

a_enables_off: assert property (@(posedge emu_mclk) disable iff (emu_initrst)
    rom_download_done |=> !prog_sdram_en && !prog_bram_en)
    else begin
        $display("ERROR t=%0t: target enable still high after done", $time);
        sva_errors++;
    end

////////////////////////////////////////////////////////////
// helpers
////////////////////////////////////////////////////////////

task automatic tick();
    @(posedge emu_mclk);
    #10;                    // inputs move just after the edge
endtask

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v    = {v[30:0], lfsr[0]};
    end
endtask

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    a_value: assert (got === exp)
        else begin
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
endtask

task automatic send_byte(input ioctl_index_t idx, input ioctl_addr_t a, input byte_t d);
    ioctl_index = idx;
    ioctl_addr  = a;
    ioctl_data  = d;
    ioctl_wr    = 1'b1;
    tick();
    ioctl_wr    = 1'b0;
    if (idx == `IOCTL_INDEX_DIPSW && a[2:0] == `DIPSW3_ADDR && !done_model) begin
        dip3_model = d[3:0];
        done_model = 1'b1;  // last dip byte ends the download
    end
endtask

// rom address to sdram location, by region in bits 19:16
task automatic map_sdram(input ioctl_addr_t a, output sdram_bank_t ba,
                         output sdram_addr_t wa, output byte_mask_t m);
    if (a[19:16] < 4'd4) begin
        ba = 2'd0;
        wa = {5'd0, a[16:0]};
        m  = a[17] ? 2'b10 : 2'b01;
    end
    else if (a[19:16] < 4'd6) begin
        ba = 2'd1;
        wa = {6'd0, a[16:1]};
        m  = a[0] ? 2'b01 : 2'b10;    // little endian pcm
    end
    else begin
        ba = 2'd0;
        wa = `PROGROM_SDRAM_BASE + {6'd0, a[15:0]};
        m  = a[16] ? 2'b10 : 2'b01;
    end
endtask

task automatic ack_write();
    int n;
    n = 0;
    while (!prog_sdram_wr && n < 20) begin
        tick();
        n++;
    end
    if (!prog_sdram_wr) begin
        $display("ERROR t=%0t: timed out waiting for SDRAM busy", $time);
        errors++;
    end
    else begin
        prog_sdram_ack = 1'b1;
        tick();
        prog_sdram_ack = 1'b0;
    end
endtask

task automatic check_inputs();
    byte_t e0;
    byte_t e1;
    byte_t e2;
    e0[0] = joystick0[5];
    e0[1] = joystick1[5];
    e0[2] = joystick0[4];
    e0[3] = joystick0[6];
    e0[4] = joystick1[6];
    e0[5] = dip3_model[0];
    e0[6] = dip3_model[1];
    e0[7] = dip3_model[2];
    e1[0] = joystick0[1];
    e1[1] = joystick0[0];
    e1[2] = joystick0[3];
    e1[3] = joystick0[2];
    e1[4] = joystick0[7];
    e1[5] = joystick0[8];
    e1[6] = joystick0[9];
    e1[7] = dip3_model[3];
    e2[0] = joystick1[1];
    e2[1] = joystick1[0];
    e2[2] = joystick1[3];
    e2[3] = joystick1[2];
    e2[4] = joystick1[7];
    e2[5] = joystick1[8];
    e2[6] = joystick0[9];     // player 2 shares pad 0 button 3
    e2[7] = 1'b1;
    compare_value("o_in0", 32'(in0), 32'(e0));
    compare_value("o_in1", 32'(in1), 32'(e1));
    compare_value("o_in2", 32'(in2), 32'(e2));
endtask

task automatic report_test(input string name);
    int e;
    e = errors + sva_errors;
    $display("%-24s finished, %0d errors", name, e - test_base);
    test_base = e;
endtask

////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////

initial begin
    logic [31:0] r;
    ioctl_addr_t a;
    byte_t       d;
    logic        vlm;
    sdram_bank_t eba;
    sdram_addr_t ewa;
    byte_mask_t  emask;

    lfsr           = 32'h333b;
    errors         = 0;
    sva_errors     = 0;
    checks         = 0;
    test_base      = 0;
    done_model     = 1'b0;
    dip3_model     = `DIPSW3_DEFAULT;
    emu_initrst    = 1'b1;
    ioctl_index    = 16'h00FF;      // neither rom nor dip
    ioctl_addr     = '0;
    ioctl_data     = '0;
    ioctl_wr       = 1'b0;
    joystick0      = '0;
    joystick1      = '0;
    prog_sdram_ack = 1'b0;

    repeat (4) @(posedge emu_mclk);
    #10;
    emu_initrst = 1'b0;

    // 1: reset state
    compare_value("o_prog_sdram_wr", 32'(prog_sdram_wr), 32'd0);
    compare_value("o_prog_bram_wr", 32'(prog_bram_wr), 32'd0);
    compare_value("o_prog_sdram_en", 32'(prog_sdram_en), 32'd0);
    compare_value("o_prog_bram_en", 32'(prog_bram_en), 32'd0);
    compare_value("o_prog_bram_sndrom_cs", 32'(prog_bram_sndrom_cs), 32'd0);
    compare_value("o_prog_bram_vlmrom_cs", 32'(prog_bram_vlmrom_cs), 32'd0);
    compare_value("o_ioctl_wait", 32'(ioctl_wait), 32'd0);
    compare_value("o_rom_download_done", 32'(rom_download_done), 32'd0);
    compare_value("o_dipsw1", 32'(dipsw1), 32'(`DIPSW1_DEFAULT));
    compare_value("o_dipsw2", 32'(dipsw2), 32'(`DIPSW2_DEFAULT));
    report_test("test 1 reset");

    // 2: block ram bytes, sound rom then speech rom
    for (int v = 0; v < 2; v++) begin
        vlm = v[0];
        take_bits(15, r);
        a = {7'd0, 1'b1, 3'd0, vlm, r[14:0]};
        take_bits(8, r);
        d = r[7:0];
        send_byte(`IOCTL_INDEX_ROM, a, d);
        compare_value("o_prog_bram_wr", 32'(prog_bram_wr), 32'd1);
        compare_value("o_prog_bram_addr", 32'(prog_bram_addr), 32'(a[15:0]));
        compare_value("o_prog_bram_din", 32'(prog_bram_din), 32'(d));
        compare_value("o_prog_bram_sndrom_cs", 32'(prog_bram_sndrom_cs), 32'(!vlm));
        compare_value("o_prog_bram_vlmrom_cs", 32'(prog_bram_vlmrom_cs), 32'(vlm));
        compare_value("o_prog_bram_en", 32'(prog_bram_en), 32'd1);
        tick();
        compare_value("o_prog_bram_wr", 32'(prog_bram_wr), 32'd0);
        compare_value("o_prog_bram_vlmrom_cs", 32'(prog_bram_vlmrom_cs), 32'(vlm));
    end
    report_test("test 2 block ram");

    // 3: graphics, pcm and program regions
    for (int k = 0; k < 3; k++) begin
        take_bits(18, r);
        if (k == 0)
            a = {7'd0, 2'b00, r[17:0]};
        else if (k == 1)
            a = {7'd0, 3'b010, r[16:0]};
        else
            a = {7'd0, 3'b011, r[16:0]};
        take_bits(8, r);
        d = r[7:0];
        map_sdram(a, eba, ewa, emask);
        send_byte(`IOCTL_INDEX_ROM, a, d);
        compare_value("o_ioctl_wait", 32'(ioctl_wait), 32'd1);
        compare_value("o_prog_sdram_en", 32'(prog_sdram_en), 32'd1);
        // a byte sent while busy is dropped
        send_byte(`IOCTL_INDEX_ROM, a ^ 27'h1, ~d);
        compare_value("o_prog_sdram_wr", 32'(prog_sdram_wr), 32'd1);
        compare_value("o_prog_sdram_ba", 32'(prog_sdram_ba), 32'(eba));
        compare_value("o_prog_sdram_addr", 32'(prog_sdram_addr), 32'(ewa));
        compare_value("o_prog_sdram_mask", 32'(prog_sdram_mask), 32'(emask));
        compare_value("o_prog_sdram_din", 32'(prog_sdram_din), 32'({d, d}));
        ack_write();
        compare_value("o_prog_sdram_wr", 32'(prog_sdram_wr), 32'd0);
        compare_value("o_ioctl_wait", 32'(ioctl_wait), 32'd0);
    end
    report_test("test 3 sdram");

    // 4: dip banks, then the download closes
    take_bits(8, r);
    send_byte(`IOCTL_INDEX_DIPSW, 27'd0, r[7:0]);
    compare_value("o_dipsw1", 32'(dipsw1), 32'(r[7:0]));
    take_bits(8, r);
    send_byte(`IOCTL_INDEX_DIPSW, 27'd1, r[7:0]);
    compare_value("o_dipsw2", 32'(dipsw2), 32'(r[7:0]));
    compare_value("o_rom_download_done", 32'(rom_download_done), 32'd0);
    take_bits(8, r);
    send_byte(`IOCTL_INDEX_DIPSW, 27'd2, r[7:0]);
    compare_value("o_rom_download_done", 32'(rom_download_done), 32'd1);
    send_byte(`IOCTL_INDEX_ROM, 27'h0_1234, 8'h5A);
    compare_value("o_prog_sdram_wr", 32'(prog_sdram_wr), 32'd0);
    compare_value("o_prog_sdram_en", 32'(prog_sdram_en), 32'd0);
    send_byte(`IOCTL_INDEX_ROM, 27'h8_1234, 8'hA5);
    compare_value("o_prog_bram_wr", 32'(prog_bram_wr), 32'd0);
    compare_value("o_prog_bram_en", 32'(prog_bram_en), 32'd0);
    report_test("test 4 dip and done");

    // 5: random pads against the bit map
    for (int i = 0; i < 16; i++) begin
        take_bits(16, r);
        joystick0 = r[15:0];
        take_bits(16, r);
        joystick1 = r[15:0];
        tick();
        check_inputs();
    end
    report_test("test 5 input bytes");

    $display("checks: %0d, errors: %0d", checks, errors + sva_errors);
    if (errors + sva_errors == 0) begin
        $display("Test OK");
    end
    else begin
        $display("Test FAILED");
    end
    $finish;
end

endmodule

//--- salamander_loader_top.sv
`timescale 1ns/1ps

module salamander_loader_top (
    input  wire                         i_EMU_MCLK,
    input  wire                         i_EMU_INITRST,

    // host download
    input  salamander_pkg::ioctl_index_t i_ioctl_index,
    input  salamander_pkg::ioctl_addr_t  i_ioctl_addr,
    input  salamander_pkg::byte_t        i_ioctl_data,
    input  wire                         i_ioctl_wr,
    output wire                         o_ioctl_wait,

    input  salamander_pkg::joystick_t    i_joystick0,
    input  salamander_pkg::joystick_t    i_joystick1,

    // sdram program port
    input  wire                         i_prog_sdram_ack,
    output wire                         o_prog_sdram_en,
    output wire                         o_prog_sdram_wr,
    output salamander_pkg::sdram_addr_t  o_prog_sdram_addr,
    output salamander_pkg::sdram_word_t  o_prog_sdram_din,
    output salamander_pkg::byte_mask_t   o_prog_sdram_mask,
    output salamander_pkg::sdram_bank_t  o_prog_sdram_ba,

    // bram program port
    output wire                         o_prog_bram_en,
    output wire                         o_prog_bram_wr,
    output salamander_pkg::bram_addr_t   o_prog_bram_addr,
    output salamander_pkg::byte_t        o_prog_bram_din,
    output wire                         o_prog_bram_sndrom_cs,
    output wire                         o_prog_bram_vlmrom_cs,

    // game board inputs
    output salamander_pkg::byte_t        o_dipsw1,
    output salamander_pkg::byte_t        o_dipsw2,
    output salamander_pkg::byte_t        o_in0,
    output salamander_pkg::byte_t        o_in1,
    output salamander_pkg::byte_t        o_in2,
    output wire                         o_rom_download_done
);

wire sdram_wr_stb;
wire bram_wr_stb;
wire dipsw_wr_stb;
wire sdram_busy;
wire rom_download_done;

assign o_prog_sdram_wr     = sdram_busy;
assign o_ioctl_wait        = sdram_busy;    // host stalls while a write is pending
assign o_rom_download_done = rom_download_done;

rom_download_router u_router (
    .i_EMU_MCLK             (i_EMU_MCLK             ),
    .i_EMU_INITRST          (i_EMU_INITRST          ),
    .i_ioctl_index          (i_ioctl_index          ),
    .i_ioctl_addr           (i_ioctl_addr           ),
    .i_ioctl_wr             (i_ioctl_wr             ),
    .i_rom_download_done    (rom_download_done      ),
    .o_sdram_wr_stb         (sdram_wr_stb           ),
    .o_bram_wr_stb          (bram_wr_stb            ),
    .o_dipsw_wr_stb         (dipsw_wr_stb           ),
    .o_prog_sdram_en        (o_prog_sdram_en        ),
    .o_prog_bram_en         (o_prog_bram_en         )
);

sdram_prog_writer u_sdram_writer (
    .i_EMU_MCLK             (i_EMU_MCLK             ),
    .i_EMU_INITRST          (i_EMU_INITRST          ),
    .i_sdram_wr_stb         (sdram_wr_stb           ),
    .i_ioctl_addr           (i_ioctl_addr           ),
    .i_ioctl_data           (i_ioctl_data           ),
    .i_prog_sdram_ack       (i_prog_sdram_ack       ),
    .o_prog_sdram_wr        (sdram_busy             ),
    .o_prog_sdram_addr      (o_prog_sdram_addr      ),
    .o_prog_sdram_din       (o_prog_sdram_din       ),
    .o_prog_sdram_mask      (o_prog_sdram_mask      ),
    .o_prog_sdram_ba        (o_prog_sdram_ba        )
);

bram_prog_writer u_bram_writer (
    .i_EMU_MCLK             (i_EMU_MCLK             ),
    .i_EMU_INITRST          (i_EMU_INITRST          ),
    .i_bram_wr_stb          (bram_wr_stb            ),
    .i_ioctl_addr           (i_ioctl_addr           ),
    .i_ioctl_data           (i_ioctl_data           ),
    .o_prog_bram_wr         (o_prog_bram_wr         ),
    .o_prog_bram_addr       (o_prog_bram_addr       ),
    .o_prog_bram_din        (o_prog_bram_din        ),
    .o_prog_bram_sndrom_cs  (o_prog_bram_sndrom_cs  ),
    .o_prog_bram_vlmrom_cs  (o_prog_bram_vlmrom_cs  )
);

control_panel u_panel (
    .i_EMU_MCLK             (i_EMU_MCLK             ),
    .i_EMU_INITRST          (i_EMU_INITRST          ),
    .i_dipsw_wr_stb         (dipsw_wr_stb           ),
    .i_ioctl_addr           (i_ioctl_addr           ),
    .i_ioctl_data           (i_ioctl_data           ),
    .i_joystick0            (i_joystick0            ),
    .i_joystick1            (i_joystick1            ),
    .o_dipsw1               (o_dipsw1               ),
    .o_dipsw2               (o_dipsw2               ),
    .o_in0                  (o_in0                  ),
    .o_in1                  (o_in1                  ),
    .o_in2                  (o_in2                  ),
    .o_rom_download_done    (rom_download_done      )
);

endmodule

//--- control_panel.sv
`timescale 1ns/1ps
`include "salamander_consts.svh"

module control_panel (
    input  wire                         i_EMU_MCLK,
    input  wire                         i_EMU_INITRST,

    input  wire                         i_dipsw_wr_stb,
    input  salamander_pkg::ioctl_addr_t  i_ioctl_addr,
    input  salamander_pkg::byte_t        i_ioctl_data,

    input  salamander_pkg::joystick_t    i_joystick0,
    input  salamander_pkg::joystick_t    i_joystick1,

    output salamander_pkg::byte_t        o_dipsw1,
    output salamander_pkg::byte_t        o_dipsw2,
    output salamander_pkg::byte_t        o_in0,
    output salamander_pkg::byte_t        o_in1,
    output salamander_pkg::byte_t        o_in2,
    output logic                        o_rom_download_done
);

import salamander_pkg::*;

//////////////////////////////////////////////////////////////
// dip banks and download done
//////////////////////////////////////////////////////////////

dipsw3_t dipsw3;    // flip, test mode, cabinet

always_ff @(posedge i_EMU_MCLK) begin
    if (i_EMU_INITRST) begin
        o_dipsw1            <= `DIPSW1_DEFAULT;
        o_dipsw2            <= `DIPSW2_DEFAULT;
        dipsw3              <= `DIPSW3_DEFAULT;
        o_rom_download_done <= 1'b0;
    end
    else if (i_dipsw_wr_stb) begin
        case (i_ioctl_addr[2:0])
            3'd0: o_dipsw1 <= i_ioctl_data;
            3'd1: o_dipsw2 <= i_ioctl_data;
            `DIPSW3_ADDR: begin
                dipsw3              <= i_ioctl_data[3:0];
                o_rom_download_done <= 1'b1;   // sticky until reset
            end
            default: ;
        endcase
    end
end

//////////////////////////////////////////////////////////////
// input bytes, snes style pad layout
//////////////////////////////////////////////////////////////

// system: coins, service, starts, then dip3
assign o_in0 = {dipsw3[2:0],
                i_joystick1[6], i_joystick0[6], i_joystick0[4],
                i_joystick1[5], i_joystick0[5]};

// player 1: left right up down, three buttons
assign o_in1 = {dipsw3[3],
                i_joystick0[9], i_joystick0[8], i_joystick0[7],
                i_joystick0[2], i_joystick0[3], i_joystick0[0], i_joystick0[1]};

// player 2 takes btn 3 from pad 0, as on the original wiring
assign o_in2 = {1'b1,
                i_joystick0[9], i_joystick1[8], i_joystick1[7],
                i_joystick1[2], i_joystick1[3], i_joystick1[0], i_joystick1[1]};

endmodule

//--- bram_prog_writer.sv
`timescale 1ns/1ps
`include "salamander_consts.svh"

module bram_prog_writer (
    input  wire                         i_EMU_MCLK,
    input  wire                         i_EMU_INITRST,

    input  wire                         i_bram_wr_stb,
    input  salamander_pkg::ioctl_addr_t  i_ioctl_addr,
    input  salamander_pkg::byte_t        i_ioctl_data,

    output logic                        o_prog_bram_wr,
    output salamander_pkg::bram_addr_t   o_prog_bram_addr,
    output salamander_pkg::byte_t        o_prog_bram_din,
    output logic                        o_prog_bram_sndrom_cs,
    output logic                        o_prog_bram_vlmrom_cs
);

// write pulse and chip selects
always_ff @(posedge i_EMU_MCLK) begin
    if (i_EMU_INITRST) begin
        o_prog_bram_wr        <= 1'b0;
        o_prog_bram_sndrom_cs <= 1'b0;
        o_prog_bram_vlmrom_cs <= 1'b0;
    end
    else begin
        o_prog_bram_wr <= i_bram_wr_stb;    // one cycle per byte
        if (i_bram_wr_stb) begin
            o_prog_bram_sndrom_cs <= ~i_ioctl_addr[`BRAM_VLM_BIT];
            o_prog_bram_vlmrom_cs <=  i_ioctl_addr[`BRAM_VLM_BIT];
        end
    end
end

// address and data, held until the next write
always_ff @(posedge i_EMU_MCLK) begin
    if (i_bram_wr_stb) begin
        o_prog_bram_addr <= i_ioctl_addr[15:0];
        o_prog_bram_din  <= i_ioctl_data;
    end
end

endmodule

//--- sdram_prog_writer.sv
`timescale 1ns/1ps
`include "salamander_consts.svh"

module sdram_prog_writer (
    input  wire                         i_EMU_MCLK,
    input  wire                         i_EMU_INITRST,

    input  wire                         i_sdram_wr_stb,
    input  salamander_pkg::ioctl_addr_t  i_ioctl_addr,
    input  salamander_pkg::byte_t        i_ioctl_data,
    input  wire                         i_prog_sdram_ack,

    output logic                        o_prog_sdram_wr,    // also busy
    output salamander_pkg::sdram_addr_t  o_prog_sdram_addr,
    output salamander_pkg::sdram_word_t  o_prog_sdram_din,
    output salamander_pkg::byte_mask_t   o_prog_sdram_mask,
    output salamander_pkg::sdram_bank_t  o_prog_sdram_ba
);

import salamander_pkg::*;

//////////////////////////////////////////////////////////////
// rom address to sdram location
//////////////////////////////////////////////////////////////

sdram_bank_t map_ba;
sdram_addr_t map_addr;
byte_mask_t  map_mask;

// bit 19 never reaches here, the router sends it to bram
always_comb begin
    case (i_ioctl_addr[19:17])
        3'b010: begin   // pcm samples, little endian
            map_ba   = 2'd1;
            map_addr = {6'd0, i_ioctl_addr[16:1]};
            map_mask = i_ioctl_addr[0] ? 2'b01 : 2'b10;
        end
        3'b011: begin   // 68k program
            map_ba   = 2'd0;
            map_addr = `PROGROM_SDRAM_BASE + {6'd0, i_ioctl_addr[15:0]};
            map_mask = i_ioctl_addr[16] ? 2'b10 : 2'b01;
        end
        default: begin  // graphics, lo/hi halves interleaved
            map_ba   = 2'd0;
            map_addr = {5'd0, i_ioctl_addr[16:0]};
            map_mask = i_ioctl_addr[17] ? 2'b10 : 2'b01;
        end
    endcase
end

//////////////////////////////////////////////////////////////
// busy/ack handshake
//////////////////////////////////////////////////////////////

sdram_wr_state_e state;

always_ff @(posedge i_EMU_MCLK) begin
    if (i_EMU_INITRST) begin
        state <= SDRAM_WR_IDLE;
    end
    else begin
        case (state)
            SDRAM_WR_IDLE: if (i_sdram_wr_stb)   state <= SDRAM_WR_BUSY;
            SDRAM_WR_BUSY: if (i_prog_sdram_ack) state <= SDRAM_WR_IDLE;
            default:                             state <= SDRAM_WR_IDLE;
        endcase
    end
end

// request payload, only taken when idle
always_ff @(posedge i_EMU_MCLK) begin
    if (state == SDRAM_WR_IDLE && i_sdram_wr_stb) begin
        o_prog_sdram_ba   <= map_ba;
        o_prog_sdram_addr <= map_addr;
        o_prog_sdram_mask <= map_mask;
        o_prog_sdram_din  <= {i_ioctl_data, i_ioctl_data};
    end
end

assign o_prog_sdram_wr = (state == SDRAM_WR_BUSY);

endmodule

//--- rom_download_router.sv
`timescale 1ns/1ps
`include "salamander_consts.svh"

module rom_download_router (
    input  wire                         i_EMU_MCLK,
    input  wire                         i_EMU_INITRST,

    input  salamander_pkg::ioctl_index_t i_ioctl_index,
    input  salamander_pkg::ioctl_addr_t  i_ioctl_addr,
    input  wire                         i_ioctl_wr,
    input  wire                         i_rom_download_done,

    output logic                        o_sdram_wr_stb,
    output logic                        o_bram_wr_stb,
    output logic                        o_dipsw_wr_stb,
    output logic                        o_prog_sdram_en,
    output logic                        o_prog_bram_en
);

//////////////////////////////////////////////////////////////
// byte classification
//////////////////////////////////////////////////////////////

logic rom_sel;
logic dip_sel;
logic bram_region;
logic live_wr;

assign rom_sel     = (i_ioctl_index == `IOCTL_INDEX_ROM);
assign dip_sel     = (i_ioctl_index == `IOCTL_INDEX_DIPSW);
assign bram_region = i_ioctl_addr[`BRAM_REGION_BIT];
assign live_wr     = i_ioctl_wr & ~i_rom_download_done;  // nothing lands after done

// one cycle strobes, one per target
assign o_sdram_wr_stb = live_wr & rom_sel & ~bram_region;
assign o_bram_wr_stb  = live_wr & rom_sel &  bram_region;
assign o_dipsw_wr_stb = live_wr & dip_sel;

//////////////////////////////////////////////////////////////
// target enables
//////////////////////////////////////////////////////////////

always_ff @(posedge i_EMU_MCLK) begin
    if (i_EMU_INITRST) begin
        o_prog_sdram_en <= 1'b0;
        o_prog_bram_en  <= 1'b0;
    end
    else if (i_rom_download_done) begin
        o_prog_sdram_en <= 1'b0;
        o_prog_bram_en  <= 1'b0;
    end
    else begin
        // follows the stream even without a write strobe
        o_prog_sdram_en <= rom_sel & ~bram_region;
        o_prog_bram_en  <= rom_sel &  bram_region;
    end
end

endmodule

//--- salamander_pkg.sv
package salamander_pkg;

    //////////////////////////////////////////////////////////
    // host download stream
    //////////////////////////////////////////////////////////

    typedef logic [15:0] ioctl_index_t;
    typedef logic [26:0] ioctl_addr_t;
    typedef logic [7:0]  byte_t;        // download data, dip bank
    typedef logic [15:0] joystick_t;
    typedef logic [3:0]  dipsw3_t;

    //////////////////////////////////////////////////////////
    // program write side
    //////////////////////////////////////////////////////////

    typedef logic [21:0] sdram_addr_t;  // word address in a bank
    typedef logic [15:0] sdram_word_t;
    typedef logic [1:0]  byte_mask_t;   // 01 = hi byte, 10 = lo byte
    typedef logic [1:0]  sdram_bank_t;
    typedef logic [15:0] bram_addr_t;

    typedef enum logic {
        SDRAM_WR_IDLE = 1'b0,
        SDRAM_WR_BUSY = 1'b1
    } sdram_wr_state_e;

endpackage

//--- salamander_consts.svh
`ifndef SALAMANDER_CONSTS_SVH
`define SALAMANDER_CONSTS_SVH

//////////////////////////////////////////////////////////////
// download stream indices
//////////////////////////////////////////////////////////////

`define IOCTL_INDEX_ROM         16'd0       // rom image
`define IOCTL_INDEX_DIPSW       16'd254     // dip switch block

//////////////////////////////////////////////////////////////
// rom image regions
//////////////////////////////////////////////////////////////

// set above 0x8_0000, block ram program area
`define BRAM_REGION_BIT         19
`define BRAM_VLM_BIT            15          // 1 = vlm5030 commands

// program rom sits after the graphics data in bank 0
`define PROGROM_SDRAM_BASE      22'h02_0000

//////////////////////////////////////////////////////////////
// dip switches
//////////////////////////////////////////////////////////////

`define DIPSW3_ADDR             3'd2        // last dip byte, ends download
`define DIPSW1_DEFAULT          8'hFF
`define DIPSW2_DEFAULT          8'h42
`define DIPSW3_DEFAULT          4'hF

`endif
